/* project.f */
+incdir+include
src/core_types_pkg.sv
src/btb_pkg.sv
src/btb_way_array.sv
src/btb_lookup.sv
src/btb_update.sv
src/btb.sv
src/btb_wrapper.sv
sim/btb_assert.sv
sim/btb_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= btb_tb
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR TIMESCALE VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(BUILD_DIR)

/* sim/btb_tb.sv */
`include "btb_consts.svh"

module btb_tb
	import core_types_pkg::*;
	import btb_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int quiet_cycles = 20;
	localparam int random_cycles = 800;
	localparam int drain_limit = 10;

	typedef struct packed {
		logic req_valid;
		logic [`BTB_LANES-1:0] hit;
		logic [`BTB_LANES-1:0] lru;
		logic [`BTB_LANES-1:0] known;
		btb_pred_info_t [`BTB_LANES-1:0] info;
		btb_target_t [`BTB_LANES-1:0] target;
	} expected_resp_t;

	logic CLK;
	logic nRST;
	logic next_valid_REQ;
	pc_t next_full_PC_REQ;
	asid_t next_ASID_REQ;
	logic [`BTB_LANES-1:0] last_hit_by_instr_RESP;
	btb_pred_info_t [`BTB_LANES-1:0] last_pred_info_by_instr_RESP;
	logic [`BTB_LANES-1:0] last_pred_lru_by_instr_RESP;
	btb_target_t [`BTB_LANES-1:0] last_target_by_instr_RESP;
	logic next_update0_valid;
	pc_t next_update0_start_full_PC;
	btb_pred_info_t next_update1_pred_info;
	logic next_update1_pred_lru;
	pc_t next_update1_target_full_PC;

	// Reference model of both ways, LRU bits and the latched ASID
	logic model_valid [2][`BTB_SETS][`BTB_LANES];
	btb_tag_t model_tag [2][`BTB_SETS][`BTB_LANES];
	btb_pred_info_t model_info [2][`BTB_SETS][`BTB_LANES];
	btb_target_t model_target [2][`BTB_SETS][`BTB_LANES];
	logic model_lru [`BTB_SETS][`BTB_LANES];
	asid_t model_asid;

	// Inputs sampled by the wrapper one edge back
	logic prev_req_valid;
	pc_t prev_req_pc;
	asid_t prev_req_asid;
	logic prev_update0_valid;
	pc_t prev_update0_pc;
	btb_pred_info_t prev_update1_info;
	logic prev_update1_lru;
	pc_t prev_update1_target;

	// Update between its array read and its write
	logic pend_valid;
	logic pend_way;
	btb_index_t pend_index;
	btb_lane_t pend_lane;
	btb_tag_t pend_tag;

	expected_resp_t expected_q [$];

	integer seed = 69;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int hit_lanes = 0;
	int replacements = 0;
	int rewrites = 0;
	int same_cycle_reads = 0;

	btb_wrapper DUT (
		.CLK(CLK),
		.nRST(nRST),
		.next_valid_REQ(next_valid_REQ),
		.next_full_PC_REQ(next_full_PC_REQ),
		.next_ASID_REQ(next_ASID_REQ),
		.last_hit_by_instr_RESP(last_hit_by_instr_RESP),
		.last_pred_info_by_instr_RESP(last_pred_info_by_instr_RESP),
		.last_pred_lru_by_instr_RESP(last_pred_lru_by_instr_RESP),
		.last_target_by_instr_RESP(last_target_by_instr_RESP),
		.next_update0_valid(next_update0_valid),
		.next_update0_start_full_PC(next_update0_start_full_PC),
		.next_update1_pred_info(next_update1_pred_info),
		.next_update1_pred_lru(next_update1_pred_lru),
		.next_update1_target_full_PC(next_update1_target_full_PC)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------

	function automatic logic [31:0] random_word();
		return $random(seed);
	endfunction

	// Small pool of PCs so that lanes collide often
	function automatic pc_t pick_pc();
		logic [31:0] r;
		logic [22:0] high;
		btb_index_t index;
		r = random_word();
		case (r[1:0])
			2'd0: high = 23'h000001;
			2'd1: high = 23'h0000a2;
			2'd2: high = 23'h100f33;
			default: high = 23'h7fffff;
		endcase
		index = r[2] ? 4'h3 : 4'ha;
		return {high, index, 2'b00, r[4:3], 1'b0};
	endfunction

	// Tag is PC 20..9 xor padded PC 31..21 xor ASID
	function automatic btb_tag_t expected_tag(input pc_t pc, input asid_t asid);
		btb_tag_t tag;
		tag = pc[20:9];
		tag = tag ^ {1'b0, pc[31:21]};
		tag = tag ^ {3'b000, asid};
		return tag;
	endfunction

	task automatic drive_inputs(input logic allow_update);
		logic [31:0] r;
		r = random_word();
		next_valid_REQ = r[1:0] != 2'b00;
		next_ASID_REQ = r[2] ? 9'h0a5 : 9'h000;
		next_update0_valid = allow_update && (r[5:3] < 3'd3);
		next_full_PC_REQ = pick_pc();
		next_update0_start_full_PC = pick_pc();
		next_update1_pred_info = r[15:8];
		next_update1_pred_lru = r[16];
		next_update1_target_full_PC = random_word();
	endtask

	task automatic drive_idle();
		next_valid_REQ = 1'b0;
		next_update0_valid = 1'b0;
	endtask

	task automatic reset_model();
		for (int way = 0; way < 2; way++) begin
			for (int set = 0; set < `BTB_SETS; set++) begin
				for (int lane = 0; lane < `BTB_LANES; lane++) begin
					model_valid[way][set][lane] = 1'b0;
					model_tag[way][set][lane] = '0;
					model_info[way][set][lane] = '0;
					model_target[way][set][lane] = '0;
					model_lru[set][lane] = 1'b0;
				end
			end
		end
		model_asid = '0;
		prev_req_valid = 1'b0;
		prev_req_pc = '0;
		prev_req_asid = '0;
		prev_update0_valid = 1'b0;
		prev_update0_pc = '0;
		prev_update1_info = '0;
		prev_update1_lru = 1'b0;
		prev_update1_target = '0;
		pend_valid = 1'b0;
		pend_way = 1'b0;
		pend_index = '0;
		pend_lane = '0;
		pend_tag = '0;
	endtask

	// ----------------------------------------
	// Model step for one clock edge
	// ----------------------------------------

	task automatic step_model();
		expected_resp_t resp;
		btb_index_t index;
		btb_tag_t tag;
		logic hit0;
		logic hit1;
		logic way;
		logic new_valid;
		logic new_way;
		btb_index_t new_index;
		btb_lane_t new_lane;
		btb_tag_t new_tag;

		// Lookup reads the arrays before this edge's write
		resp = '0;
		resp.req_valid = prev_req_valid;
		index = prev_req_pc[8:5];
		tag = expected_tag(prev_req_pc, prev_req_asid);
		for (int lane = 0; lane < `BTB_LANES; lane++) begin
			hit0 = model_valid[0][index][lane] && (model_tag[0][index][lane] == tag);
			hit1 = model_valid[1][index][lane] && (model_tag[1][index][lane] == tag);
			// Way 0 first, and way 0 as well on a miss
			way = !hit0 && hit1;
			resp.lru[lane] = model_lru[index][lane];
			resp.known[lane] = model_valid[way][index][lane];
			resp.info[lane] = model_info[way][index][lane];
			resp.target[lane] = model_target[way][index][lane];
			if (prev_req_valid && (hit0 || hit1)) begin
				resp.hit[lane] = 1'b1;
				hit_lanes++;
			end
		end
		expected_q.push_back(resp);

		// Way choice of the update0 sampled one edge back
		new_valid = prev_update0_valid;
		new_index = prev_update0_pc[8:5];
		new_lane = prev_update0_pc[4:1];
		new_tag = expected_tag(prev_update0_pc, model_asid);
		new_way = 1'b0;
		if (new_valid) begin
			hit0 = model_valid[0][new_index][new_lane] &&
				(model_tag[0][new_index][new_lane] == new_tag);
			hit1 = model_valid[1][new_index][new_lane] &&
				(model_tag[1][new_index][new_lane] == new_tag);
			if (hit0) begin
				new_way = 1'b0;
			end else if (hit1) begin
				new_way = 1'b1;
			end else begin
				new_way = model_lru[new_index][new_lane];
			end
			if (hit0 || hit1) begin
				rewrites++;
			end else if (model_valid[0][new_index][new_lane] &&
				model_valid[1][new_index][new_lane]) begin
				replacements++;
			end
		end

		// Write with the update1 fields sampled one edge back
		if (pend_valid) begin
			if (prev_req_valid && (prev_req_pc[8:5] == pend_index)) begin
				same_cycle_reads++;
			end
			model_valid[pend_way][pend_index][pend_lane] = 1'b1;
			model_tag[pend_way][pend_index][pend_lane] = pend_tag;
			model_info[pend_way][pend_index][pend_lane] = prev_update1_info;
			model_target[pend_way][pend_index][pend_lane] = prev_update1_target[10:1];
			model_lru[pend_index][pend_lane] = prev_update1_lru;
		end
		pend_valid = new_valid;
		pend_way = new_way;
		pend_index = new_index;
		pend_lane = new_lane;
		pend_tag = new_tag;

		if (prev_req_valid) begin
			model_asid = prev_req_asid;
		end

		// Inputs the wrapper took at this edge
		prev_req_valid = next_valid_REQ;
		prev_req_pc = next_full_PC_REQ;
		prev_req_asid = next_ASID_REQ;
		prev_update0_valid = next_update0_valid;
		prev_update0_pc = next_update0_start_full_PC;
		prev_update1_info = next_update1_pred_info;
		prev_update1_lru = next_update1_pred_lru;
		prev_update1_target = next_update1_target_full_PC;
	endtask

	// ----------------------------------------
	// Response check
	// ----------------------------------------

	task automatic check_response();
		expected_resp_t want;
		if (expected_q.size() > 0) begin
			want = expected_q.pop_front();
			checks++;
			if (last_hit_by_instr_RESP !== want.hit) begin
				errors++;
				$display("Mismatch last_hit_by_instr_RESP at cycle %0d: got %h, expected %h",
					cycle, last_hit_by_instr_RESP, want.hit);
			end
			if (last_pred_lru_by_instr_RESP !== want.lru) begin
				errors++;
				$display("Mismatch last_pred_lru_by_instr_RESP at cycle %0d: got %h, expected %h",
					cycle, last_pred_lru_by_instr_RESP, want.lru);
			end
			// Payload compared wherever the selected way holds a written entry
			for (int lane = 0; lane < `BTB_LANES; lane++) begin
				if (want.known[lane] &&
					(last_pred_info_by_instr_RESP[lane] !== want.info[lane])) begin
					errors++;
					$display("Mismatch %s[%0d] at cycle %0d: got %h, expected %h",
						"last_pred_info_by_instr_RESP", lane, cycle,
						last_pred_info_by_instr_RESP[lane], want.info[lane]);
				end
				if (want.known[lane] &&
					(last_target_by_instr_RESP[lane] !== want.target[lane])) begin
					errors++;
					$display("Mismatch %s[%0d] at cycle %0d: got %h, expected %h",
						"last_target_by_instr_RESP", lane, cycle,
						last_target_by_instr_RESP[lane], want.target[lane]);
				end
			end
		end
	endtask

	task automatic run_cycle(input logic active, input logic allow_update);
		@(negedge CLK);
		cycle++;
		check_response();
		step_model();
		if (active) begin
			drive_inputs(allow_update);
		end else begin
			drive_idle();
		end
	endtask

	function automatic int requests_in_flight();
		int count;
		count = 0;
		foreach (expected_q[i]) begin
			if (expected_q[i].req_valid) begin
				count++;
			end
		end
		if (prev_req_valid) begin
			count++;
		end
		if (next_valid_REQ) begin
			count++;
		end
		return count;
	endfunction

	task automatic drain_responses();
		int waited;
		waited = 0;
		while ((requests_in_flight() > 0) && (waited < drain_limit)) begin
			run_cycle(1'b0, 1'b0);
			waited++;
		end
		if (requests_in_flight() > 0) begin
			errors++;
			$display("Timeout: %0d requests still had no response after %0d cycles",
				requests_in_flight(), waited);
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		nRST = 1'b0;
		next_valid_REQ = 1'b0;
		next_full_PC_REQ = '0;
		next_ASID_REQ = '0;
		next_update0_valid = 1'b0;
		next_update0_start_full_PC = '0;
		next_update1_pred_info = '0;
		next_update1_pred_lru = 1'b0;
		next_update1_target_full_PC = '0;
		reset_model();

		repeat (10) @(negedge CLK);
		nRST = 1'b1;
		drive_inputs(1'b0);

		// Requests only so the BTB stays empty
		for (int i = 0; i < quiet_cycles; i++) begin
			run_cycle(1'b1, 1'b0);
		end

		// Requests and overlapping updates
		for (int i = 0; i < random_cycles; i++) begin
			run_cycle(1'b1, 1'b1);
		end

		drain_responses();

		if (hit_lanes == 0) begin
			errors++;
			$display("No request ever hit a written entry");
		end
		if (replacements == 0) begin
			errors++;
			$display("No update ever replaced a full lane by its LRU bit");
		end
		if (rewrites == 0) begin
			errors++;
			$display("No update ever rewrote an existing tag");
		end
		if (same_cycle_reads == 0) begin
			errors++;
			$display("No request ever read a set in the cycle of its write");
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* sim/btb_assert.sv */
module btb_assert (
	input logic CLK,
	input logic nRST,
	input logic update0_valid,
	input logic wr_en_way0,
	input logic wr_en_way1
);

	timeunit 1ns;
	timeprecision 1ps;

	// ----------------------------------------
	// Update write rules
	// ----------------------------------------

	// One update writes one way only
	one_way_per_write: assert property (@(posedge CLK) disable iff (!nRST)
		!(wr_en_way0 && wr_en_way1))
	else $error("Both ways written in the same cycle");

	// Writes come from stage 2 of an update0
	write_after_update0: assert property (@(posedge CLK) disable iff (!nRST)
		(wr_en_way0 || wr_en_way1) |-> ($past(update0_valid, 1) || $past(update0_valid, 2)))
	else $error("Way written without an update0 in the two cycles before");

endmodule

bind btb btb_assert write_checks (
	.CLK(CLK),
	.nRST(nRST),
	.update0_valid(update0_valid),
	.wr_en_way0(wr_en_way0),
	.wr_en_way1(wr_en_way1)
);

/* src/btb_wrapper.sv */
`include "btb_consts.svh"

module btb_wrapper
	import core_types_pkg::*;
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// REQ stage
	input logic next_valid_REQ,
	input pc_t next_full_PC_REQ,
	input asid_t next_ASID_REQ,

	// RESP stage
	output logic [`BTB_LANES-1:0] last_hit_by_instr_RESP,
	output btb_pred_info_t [`BTB_LANES-1:0] last_pred_info_by_instr_RESP,
	output logic [`BTB_LANES-1:0] last_pred_lru_by_instr_RESP,
	output btb_target_t [`BTB_LANES-1:0] last_target_by_instr_RESP,

	// Update 0
	input logic next_update0_valid,
	input pc_t next_update0_start_full_PC,

	// Update 1
	input btb_pred_info_t next_update1_pred_info,
	input logic next_update1_pred_lru,
	input pc_t next_update1_target_full_PC
);

	logic valid_REQ;
	pc_t full_PC_REQ;
	asid_t ASID_REQ;

	logic [`BTB_LANES-1:0] hit_by_instr_RESP;
	btb_pred_info_t [`BTB_LANES-1:0] pred_info_by_instr_RESP;
	logic [`BTB_LANES-1:0] pred_lru_by_instr_RESP;
	btb_target_t [`BTB_LANES-1:0] target_by_instr_RESP;

	logic update0_valid;
	pc_t update0_start_full_PC;
	btb_pred_info_t update1_pred_info;
	logic update1_pred_lru;
	pc_t update1_target_full_PC;

	btb core (
		.CLK(CLK),
		.nRST(nRST),
		.valid_REQ(valid_REQ),
		.full_PC_REQ(full_PC_REQ),
		.ASID_REQ(ASID_REQ),
		.hit_by_instr_RESP(hit_by_instr_RESP),
		.pred_info_by_instr_RESP(pred_info_by_instr_RESP),
		.pred_lru_by_instr_RESP(pred_lru_by_instr_RESP),
		.target_by_instr_RESP(target_by_instr_RESP),
		.update0_valid(update0_valid),
		.update0_start_full_PC(update0_start_full_PC),
		.update1_pred_info(update1_pred_info),
		.update1_pred_lru(update1_pred_lru),
		.update1_target_full_PC(update1_target_full_PC)
	);

	// ----------------------------------------
	// Boundary registers
	// ----------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_REQ <= 1'b0;
			full_PC_REQ <= '0;
			ASID_REQ <= '0;
			last_hit_by_instr_RESP <= '0;
			last_pred_info_by_instr_RESP <= '0;
			last_pred_lru_by_instr_RESP <= '0;
			last_target_by_instr_RESP <= '0;
			update0_valid <= 1'b0;
			update0_start_full_PC <= '0;
			update1_pred_info <= '0;
			update1_pred_lru <= 1'b0;
			update1_target_full_PC <= '0;
		end else begin
			// Inputs into the core
			valid_REQ <= next_valid_REQ;
			full_PC_REQ <= next_full_PC_REQ;
			ASID_REQ <= next_ASID_REQ;
			update0_valid <= next_update0_valid;
			update0_start_full_PC <= next_update0_start_full_PC;
			update1_pred_info <= next_update1_pred_info;
			update1_pred_lru <= next_update1_pred_lru;
			update1_target_full_PC <= next_update1_target_full_PC;
			// Core response out
			last_hit_by_instr_RESP <= hit_by_instr_RESP;
			last_pred_info_by_instr_RESP <= pred_info_by_instr_RESP;
			last_pred_lru_by_instr_RESP <= pred_lru_by_instr_RESP;
			last_target_by_instr_RESP <= target_by_instr_RESP;
		end
	end

endmodule

/* src/btb.sv */
`include "btb_consts.svh"

module btb
	import core_types_pkg::*;
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// REQ stage
	input logic valid_REQ,
	input pc_t full_PC_REQ,
	input asid_t ASID_REQ,

	// RESP stage
	output logic [`BTB_LANES-1:0] hit_by_instr_RESP,
	output btb_pred_info_t [`BTB_LANES-1:0] pred_info_by_instr_RESP,
	output logic [`BTB_LANES-1:0] pred_lru_by_instr_RESP,
	output btb_target_t [`BTB_LANES-1:0] target_by_instr_RESP,

	// Update 0
	input logic update0_valid,
	input pc_t update0_start_full_PC,

	// Update 1
	input btb_pred_info_t update1_pred_info,
	input logic update1_pred_lru,
	input pc_t update1_target_full_PC
);

	asid_t latched_asid;
	btb_index_t req_index;
	btb_tag_t req_tag;

	logic [`BTB_LANES-1:0] way0_rd_valid, way1_rd_valid;
	btb_tag_t [`BTB_LANES-1:0] way0_rd_tag, way1_rd_tag;
	btb_pred_info_t [`BTB_LANES-1:0] way0_rd_pred_info, way1_rd_pred_info;
	btb_target_t [`BTB_LANES-1:0] way0_rd_target, way1_rd_target;
	logic [`BTB_LANES-1:0] way0_upd_valid, way1_upd_valid;
	btb_tag_t [`BTB_LANES-1:0] way0_upd_tag, way1_upd_tag;

	logic [`BTB_LANES-1:0] lru_array [`BTB_SETS];
	logic [`BTB_LANES-1:0] rd_lru;
	logic [`BTB_LANES-1:0] upd_lru;

	btb_index_t upd_index;
	logic wr_en_way0;
	logic wr_en_way1;
	btb_index_t wr_index;
	btb_lane_t wr_lane;
	btb_tag_t wr_tag;
	btb_pred_info_t wr_pred_info;
	btb_target_t wr_target;
	logic lru_wr_en;
	logic lru_wr_data;

	// ----------------------------------------
	// Request tag and ASID latch
	// ----------------------------------------

	assign req_index = full_PC_REQ[8:5];
	assign req_tag = btb_fold_tag(full_PC_REQ, ASID_REQ);

	// Updates fold their tag with the last requested ASID
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			latched_asid <= '0;
		end else if (valid_REQ) begin
			latched_asid <= ASID_REQ;
		end
	end

	// ----------------------------------------
	// LRU bits, read before write
	// ----------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru_array <= '{default: '0};
			rd_lru <= '0;
			upd_lru <= '0;
		end else begin
			if (lru_wr_en) begin
				lru_array[wr_index][wr_lane] <= lru_wr_data;
			end
			rd_lru <= lru_array[req_index];
			upd_lru <= lru_array[upd_index];
		end
	end

	// ----------------------------------------
	// Ways, lookup and update
	// ----------------------------------------

	btb_way_array way0 (
		.CLK(CLK), .nRST(nRST),
		.rd_index(req_index), .rd_valid(way0_rd_valid), .rd_tag(way0_rd_tag),
		.rd_pred_info(way0_rd_pred_info), .rd_target(way0_rd_target),
		.upd_index(upd_index), .upd_valid(way0_upd_valid), .upd_tag(way0_upd_tag),
		.wr_en(wr_en_way0), .wr_index(wr_index), .wr_lane(wr_lane), .wr_tag(wr_tag),
		.wr_pred_info(wr_pred_info), .wr_target(wr_target)
	);

	btb_way_array way1 (
		.CLK(CLK), .nRST(nRST),
		.rd_index(req_index), .rd_valid(way1_rd_valid), .rd_tag(way1_rd_tag),
		.rd_pred_info(way1_rd_pred_info), .rd_target(way1_rd_target),
		.upd_index(upd_index), .upd_valid(way1_upd_valid), .upd_tag(way1_upd_tag),
		.wr_en(wr_en_way1), .wr_index(wr_index), .wr_lane(wr_lane), .wr_tag(wr_tag),
		.wr_pred_info(wr_pred_info), .wr_target(wr_target)
	);

	btb_lookup lookup (
		.CLK(CLK), .nRST(nRST),
		.req_valid(valid_REQ), .req_tag(req_tag),
		.way0_rd_valid(way0_rd_valid), .way0_rd_tag(way0_rd_tag),
		.way0_rd_pred_info(way0_rd_pred_info), .way0_rd_target(way0_rd_target),
		.way1_rd_valid(way1_rd_valid), .way1_rd_tag(way1_rd_tag),
		.way1_rd_pred_info(way1_rd_pred_info), .way1_rd_target(way1_rd_target),
		.rd_lru(rd_lru),
		.hit_by_instr_RESP(hit_by_instr_RESP),
		.pred_info_by_instr_RESP(pred_info_by_instr_RESP),
		.pred_lru_by_instr_RESP(pred_lru_by_instr_RESP),
		.target_by_instr_RESP(target_by_instr_RESP)
	);

	btb_update update (
		.CLK(CLK), .nRST(nRST),
		.update0_valid(update0_valid), .update0_start_full_PC(update0_start_full_PC),
		.latched_asid(latched_asid),
		.way0_upd_valid(way0_upd_valid), .way0_upd_tag(way0_upd_tag),
		.way1_upd_valid(way1_upd_valid), .way1_upd_tag(way1_upd_tag),
		.upd_lru(upd_lru),
		.update1_pred_info(update1_pred_info), .update1_pred_lru(update1_pred_lru),
		.update1_target_full_PC(update1_target_full_PC),
		.upd_index(upd_index),
		.wr_en_way0(wr_en_way0), .wr_en_way1(wr_en_way1),
		.wr_index(wr_index), .wr_lane(wr_lane), .wr_tag(wr_tag),
		.wr_pred_info(wr_pred_info), .wr_target(wr_target),
		.lru_wr_en(lru_wr_en), .lru_wr_data(lru_wr_data)
	);

endmodule

/* src/btb_update.sv */
`include "btb_consts.svh"

module btb_update
	import core_types_pkg::*;
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// Update 0
	input logic update0_valid,
	input pc_t update0_start_full_PC,
	input asid_t latched_asid,

	// Update read data
	input logic [`BTB_LANES-1:0] way0_upd_valid,
	input btb_tag_t [`BTB_LANES-1:0] way0_upd_tag,
	input logic [`BTB_LANES-1:0] way1_upd_valid,
	input btb_tag_t [`BTB_LANES-1:0] way1_upd_tag,
	input logic [`BTB_LANES-1:0] upd_lru,

	// Update 1
	input btb_pred_info_t update1_pred_info,
	input logic update1_pred_lru,
	input pc_t update1_target_full_PC,

	output btb_index_t upd_index,

	// Entry and LRU write
	output logic wr_en_way0,
	output logic wr_en_way1,
	output btb_index_t wr_index,
	output btb_lane_t wr_lane,
	output btb_tag_t wr_tag,
	output btb_pred_info_t wr_pred_info,
	output btb_target_t wr_target,
	output logic lru_wr_en,
	output logic lru_wr_data
);

	logic s1_valid;
	btb_index_t s1_index;
	btb_lane_t s1_lane;
	btb_tag_t s1_tag;
	logic hit_way0;
	logic hit_way1;
	logic sel_way1;

	assign upd_index = update0_start_full_PC[8:5];

	// ----------------------------------------
	// Stage 1, arrays read
	// ----------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= update0_valid;
		end
	end

	always_ff @(posedge CLK) begin
		s1_index <= upd_index;
		s1_lane <= update0_start_full_PC[4:1];
		s1_tag <= btb_fold_tag(update0_start_full_PC, latched_asid);
	end

	// ----------------------------------------
	// Stage 2, way select and write
	// ----------------------------------------

	assign hit_way0 = way0_upd_valid[s1_lane] && (way0_upd_tag[s1_lane] == s1_tag);
	assign hit_way1 = way1_upd_valid[s1_lane] && (way1_upd_tag[s1_lane] == s1_tag);

	// Tag match first, else the way named by LRU
	assign sel_way1 = hit_way0 ? 1'b0 : (hit_way1 ? 1'b1 : upd_lru[s1_lane]);

	assign wr_en_way0 = s1_valid && !sel_way1;
	assign wr_en_way1 = s1_valid && sel_way1;
	assign wr_index = s1_index;
	assign wr_lane = s1_lane;
	assign wr_tag = s1_tag;
	assign wr_pred_info = update1_pred_info;
	assign wr_target = update1_target_full_PC[`BTB_TARGET_WIDTH:1];

	assign lru_wr_en = s1_valid;
	assign lru_wr_data = update1_pred_lru;

endmodule

/* src/btb_lookup.sv */
`include "btb_consts.svh"

module btb_lookup
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// Request, one cycle ahead of the read data
	input logic req_valid,
	input btb_tag_t req_tag,

	// Way 0 read data
	input logic [`BTB_LANES-1:0] way0_rd_valid,
	input btb_tag_t [`BTB_LANES-1:0] way0_rd_tag,
	input btb_pred_info_t [`BTB_LANES-1:0] way0_rd_pred_info,
	input btb_target_t [`BTB_LANES-1:0] way0_rd_target,

	// Way 1 read data
	input logic [`BTB_LANES-1:0] way1_rd_valid,
	input btb_tag_t [`BTB_LANES-1:0] way1_rd_tag,
	input btb_pred_info_t [`BTB_LANES-1:0] way1_rd_pred_info,
	input btb_target_t [`BTB_LANES-1:0] way1_rd_target,

	input logic [`BTB_LANES-1:0] rd_lru,

	// RESP stage
	output logic [`BTB_LANES-1:0] hit_by_instr_RESP,
	output btb_pred_info_t [`BTB_LANES-1:0] pred_info_by_instr_RESP,
	output logic [`BTB_LANES-1:0] pred_lru_by_instr_RESP,
	output btb_target_t [`BTB_LANES-1:0] target_by_instr_RESP
);

	logic req_valid_q;
	btb_tag_t req_tag_q;
	logic [`BTB_LANES-1:0] hit_way0;
	logic [`BTB_LANES-1:0] hit_way1;

	// Align the request with the array read
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			req_valid_q <= 1'b0;
		end else begin
			req_valid_q <= req_valid;
		end
	end

	always_ff @(posedge CLK) begin
		req_tag_q <= req_tag;
	end

	// ----------------------------------------
	// Per-lane compare
	// ----------------------------------------

	always_comb begin
		for (int lane = 0; lane < `BTB_LANES; lane++) begin
			hit_way0[lane] = way0_rd_valid[lane] && (way0_rd_tag[lane] == req_tag_q);
			hit_way1[lane] = way1_rd_valid[lane] && (way1_rd_tag[lane] == req_tag_q);
			hit_by_instr_RESP[lane] = req_valid_q && (hit_way0[lane] || hit_way1[lane]);
			// Way 1 data only when way 0 misses, way 0 on a full miss
			if (hit_way1[lane] && !hit_way0[lane]) begin
				pred_info_by_instr_RESP[lane] = way1_rd_pred_info[lane];
				target_by_instr_RESP[lane] = way1_rd_target[lane];
			end else begin
				pred_info_by_instr_RESP[lane] = way0_rd_pred_info[lane];
				target_by_instr_RESP[lane] = way0_rd_target[lane];
			end
		end
	end

	assign pred_lru_by_instr_RESP = rd_lru;

endmodule

/* src/btb_way_array.sv */
`include "btb_consts.svh"

module btb_way_array
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	// Lookup read port
	input btb_index_t rd_index,
	output logic [`BTB_LANES-1:0] rd_valid,
	output btb_tag_t [`BTB_LANES-1:0] rd_tag,
	output btb_pred_info_t [`BTB_LANES-1:0] rd_pred_info,
	output btb_target_t [`BTB_LANES-1:0] rd_target,

	// Update read port
	input btb_index_t upd_index,
	output logic [`BTB_LANES-1:0] upd_valid,
	output btb_tag_t [`BTB_LANES-1:0] upd_tag,

	// Single lane write
	input logic wr_en,
	input btb_index_t wr_index,
	input btb_lane_t wr_lane,
	input btb_tag_t wr_tag,
	input btb_pred_info_t wr_pred_info,
	input btb_target_t wr_target
);

	logic [`BTB_LANES-1:0] valid_array [`BTB_SETS];
	btb_tag_t [`BTB_LANES-1:0] tag_array [`BTB_SETS];
	btb_pred_info_t [`BTB_LANES-1:0] pred_info_array [`BTB_SETS];
	btb_target_t [`BTB_LANES-1:0] target_array [`BTB_SETS];

	// ----------------------------------------
	// Valid bits
	// ----------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_array <= '{default: '0};
			rd_valid <= '0;
			upd_valid <= '0;
		end else begin
			if (wr_en) begin
				valid_array[wr_index][wr_lane] <= 1'b1;
			end
			// Reads return the contents before this edge's write
			rd_valid <= valid_array[rd_index];
			upd_valid <= valid_array[upd_index];
		end
	end

	// ----------------------------------------
	// Entry payload
	// ----------------------------------------

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			tag_array[wr_index][wr_lane] <= wr_tag;
			pred_info_array[wr_index][wr_lane] <= wr_pred_info;
			target_array[wr_index][wr_lane] <= wr_target;
		end
		rd_tag <= tag_array[rd_index];
		rd_pred_info <= pred_info_array[rd_index];
		rd_target <= target_array[rd_index];
		upd_tag <= tag_array[upd_index];
	end

endmodule

/* src/btb_pkg.sv */
`include "btb_consts.svh"

package btb_pkg;

	import core_types_pkg::*;

	// ----------------------------------------
	// Entry field types
	// ----------------------------------------

	// Set index, PC bits 8 to 5
	typedef logic [`BTB_INDEX_WIDTH-1:0] btb_index_t;

	// Parcel lane, PC bits 4 to 1
	typedef logic [$clog2(`BTB_LANES)-1:0] btb_lane_t;

	typedef logic [`BTB_TAG_WIDTH-1:0] btb_tag_t;

	typedef logic [`BTB_PRED_INFO_WIDTH-1:0] btb_pred_info_t;

	// Compressed target, PC bits 10 to 1
	typedef logic [`BTB_TARGET_WIDTH-1:0] btb_target_t;

	// ----------------------------------------
	// Tag folding
	// ----------------------------------------

	// XOR of the PC bits above the index, the high PC bits and the ASID
	function automatic btb_tag_t btb_fold_tag(input pc_t pc, input asid_t asid);
		btb_tag_t low_bits;
		btb_tag_t high_bits;
		btb_tag_t asid_bits;
		low_bits = pc[20:9];
		// Upper 11 PC bits, zero padded
		high_bits = btb_tag_t'(pc[31:21]);
		asid_bits = btb_tag_t'(asid);
		return low_bits ^ high_bits ^ asid_bits;
	endfunction

endpackage

/* src/core_types_pkg.sv */
package core_types_pkg;

	// ----------------------------------------
	// Core-wide widths
	// ----------------------------------------

	// Full fetch PC, byte address
	typedef logic [31:0] pc_t;

	// Address-space ID
	typedef logic [8:0] asid_t;

endpackage

/* include/btb_consts.svh */
`ifndef BTB_CONSTS_SVH
`define BTB_CONSTS_SVH

// ----------------------------------------
// BTB geometry
// ----------------------------------------

// Sets per way
`define BTB_SETS 16

// Set index taken from PC bits 8 to 5
`define BTB_INDEX_WIDTH 4

// Parcel lanes in one 32-byte fetch block
`define BTB_LANES 16

// ----------------------------------------
// Entry fields
// ----------------------------------------

// Folded tag of PC and ASID
`define BTB_TAG_WIDTH 12

// Opaque info for the direction predictors
`define BTB_PRED_INFO_WIDTH 8

// Target PC bits 10 to 1
`define BTB_TARGET_WIDTH 10

`endif
